/* all.f */
+incdir+hw
hw/uart_dbg_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/dbg_mem.sv
hw/dbg_cmd_engine.sv
hw/uart_dbg_top.sv
dv/tb_clk_gen.sv
dv/uart_dbg_assert.sv
dv/uart_dbg_tb.sv

/* dv/tb_clk_gen.sv */
/* Testbench clock and reset
   100 ns clock, reset held high for the first two cycles */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Released just after the second rising edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

/* dv/uart_dbg_assert.sv */
/* UART debug bridge assertions
   Exec pulse width, line idle in reset, exec only after a full stop bit */

`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_dbg_assert import uart_dbg_pkg::*; (
  input logic      clk,
  input logic      rst_i,
  input logic      uart_tx_i,
  input exec_req_t exec_i
);

  localparam int unsigned CPB = `UART_CLKS_PER_BIT;

  logic [7:0] high_cnt_q;
  logic       low_seen_q;

  // Length of the current high run, saturating at one bit period
  always_ff @(posedge clk) begin
    if (rst_i) begin
      high_cnt_q <= '0;
      low_seen_q <= 1'b0;
    end else begin
      if (!uart_tx_i) begin
        high_cnt_q <= '0;
      end else if (high_cnt_q < 8'(CPB)) begin
        high_cnt_q <= high_cnt_q + 1'b1;
      end
      // A frame has gone out since the last exec
      if (exec_i.valid) begin
        low_seen_q <= 1'b0;
      end else if (!uart_tx_i) begin
        low_seen_q <= 1'b1;
      end
    end
  end

  exec_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
    exec_i.valid |=> !exec_i.valid)
    else $error("exec_o.valid held high for more than one cycle");

  tx_idle_in_reset: assert property (@(posedge clk)
    rst_i |=> uart_tx_i)
    else $error("uart_tx_o not high during or right after reset");

  exec_after_stop: assert property (@(posedge clk) disable iff (rst_i)
    $rose(exec_i.valid) |-> (low_seen_q && high_cnt_q == 8'(CPB)))
    else $error("exec_o.valid rose without a preceding stop bit on uart_tx_o");

endmodule

bind uart_dbg_top uart_dbg_assert u_uart_dbg_assert (
  .clk       ( clk       ),
  .rst_i     ( rst_i     ),
  .uart_tx_i ( uart_tx_o ),
  .exec_i    ( exec_o    )
);

/* dv/uart_dbg_tb.sv */
/* UART debug bridge testbench
   Table-driven serial host that sends commands and checks replies and exec pulses */

`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_dbg_tb import uart_dbg_pkg::*; ();

  localparam int CPB          = `UART_CLKS_PER_BIT;
  localparam int FRAME_CYC    = 10 * CPB;
  localparam int QUIET_FRAMES = 2;
  localparam int DRV_DLY      = 1;
  localparam int NROWS        = 15;

  // Protocol bytes as the host sees them
  localparam logic [7:0] HOST_ACK   = 8'h06;
  localparam logic [7:0] HOST_EOT   = 8'h04;
  localparam logic [7:0] HOST_READ  = 8'h11;
  localparam logic [7:0] HOST_WRITE = 8'h12;
  localparam logic [7:0] HOST_EXEC  = 8'h13;

  typedef enum int {OP_CHAL, OP_WRITE, OP_READ, OP_EXEC, OP_JUNK, OP_BADFRAME} op_e;

  typedef struct {
    op_e         op;
    logic [63:0] addr;
    logic [63:0] len;
    logic [7:0]  pat;
    logic [63:0] entry;
  } row_t;

  logic      clk;
  logic      rst;
  logic      uart_rx;
  logic      uart_tx;
  exec_req_t exec_req;

  row_t        rows [NROWS];
  logic [7:0]  model_mem [256];
  logic [7:0]  reply_q [$];
  logic [63:0] exec_q [$];
  integer      seed;
  int unsigned cycle_cnt;
  int unsigned limit_cyc;
  int unsigned value_errs;
  int unsigned proto_errs;

  tb_clk_gen u_tb_clk_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  uart_dbg_top u_uart_dbg_top (
    .clk       ( clk      ),
    .rst_i     ( rst      ),
    .uart_rx_i ( uart_rx  ),
    .uart_tx_o ( uart_tx  ),
    .exec_o    ( exec_req )
  );

  ////////////////////
  // Stimulus table
  ////////////////////

  task automatic load_table();
    //          op           addr                    len     pat    entry
    rows[0]  = '{OP_CHAL,     64'h0,                  64'd0,  8'h00, 64'h0};
    rows[1]  = '{OP_WRITE,    64'h10,                 64'd8,  8'h00, 64'h0};
    rows[2]  = '{OP_READ,     64'h10,                 64'd8,  8'h00, 64'h0};
    // Upper address bytes alias, burst wraps past 255
    rows[3]  = '{OP_WRITE,    64'h1234_5678_9abc_01fa, 64'd10, 8'h5a, 64'h0};
    rows[4]  = '{OP_READ,     64'hfa,                 64'd10, 8'h00, 64'h0};
    rows[5]  = '{OP_EXEC,     64'h8000_0000_0000_1000, 64'd0,  8'h00, 64'h8000_0000_0000_1000};
    rows[6]  = '{OP_JUNK,     64'h0,                  64'd0,  8'h55, 64'h0};
    rows[7]  = '{OP_CHAL,     64'h0,                  64'd0,  8'h00, 64'h0};
    // ACK byte with a low stop bit
    rows[8]  = '{OP_BADFRAME, 64'h0,                  64'd0,  8'h06, 64'h0};
    rows[9]  = '{OP_CHAL,     64'h0,                  64'd0,  8'h00, 64'h0};
    rows[10] = '{OP_WRITE,    64'h10,                 64'd0,  8'h00, 64'h0};
    rows[11] = '{OP_READ,     64'h10,                 64'd0,  8'h00, 64'h0};
    rows[12] = '{OP_READ,     64'h10,                 64'd8,  8'h00, 64'h0};
    rows[13] = '{OP_EXEC,     64'hfedc_ba98_7654_3210, 64'd0,  8'h00, 64'hfedc_ba98_7654_3210};
    rows[14] = '{OP_READ,     64'h0000_0100_0000_0000, 64'd4,  8'h00, 64'h0};
  endtask

  // Host frames, reply frames and quiet time of every row
  function automatic int unsigned frame_budget();
    int unsigned frames;
    int unsigned n;
    frames = 0;
    for (int r = 0; r < NROWS; r++) begin
      n = 32'(rows[r].len[`DBG_LEN_W-1:0]);
      case (rows[r].op)
        OP_WRITE: frames += 17 + n + 2;
        OP_READ:  frames += 17 + n + 2;
        OP_EXEC:  frames += 9 + 1;
        OP_CHAL:  frames += 1 + 1;
        default:  frames += 1;
      endcase
      frames += QUIET_FRAMES;
    end
    return frames * FRAME_CYC * 2;
  endfunction

  ////////////////////
  // Host serial model
  ////////////////////

  task automatic drive_bit(input logic v);
    uart_rx = v;
    repeat (CPB) @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic send_byte(input logic [7:0] b, input logic stop_bit);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(stop_bit);
    uart_rx = 1'b1;
  endtask

  // Little endian, low byte first
  task automatic send_field(input logic [63:0] v);
    for (int i = 0; i < 8; i++) begin
      send_byte(v[8*i +: 8], 1'b1);
    end
  endtask

  task automatic wait_replies(input int n);
    while (reply_q.size() < n) begin
      @(posedge clk);
      #DRV_DLY;
    end
  endtask

  // Receiver samples each bit at its middle
  initial begin : host_rx
    logic [7:0] b;
    wait (rst == 1'b0);
    forever begin
      @(negedge clk);
      if (uart_tx === 1'b0) begin
        repeat (CPB / 2 - 1) @(negedge clk);
        if (uart_tx !== 1'b0) begin
          proto_errs++;
          $display("Start bit on uart_tx_o did not last to its middle at %0t", $time);
        end
        for (int i = 0; i < 8; i++) begin
          repeat (CPB) @(negedge clk);
          b[i] = uart_tx;
        end
        repeat (CPB) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          proto_errs++;
          $display("Stop bit on uart_tx_o was low at %0t", $time);
        end
        reply_q.push_back(b);
      end
    end
  end

  always @(negedge clk) begin
    if (rst === 1'b0 && exec_req.valid === 1'b1) begin
      exec_q.push_back(exec_req.entry);
    end
  end

  ////////////////////
  // Row sequencing
  ////////////////////

  task automatic run_row(input int r);
    logic [7:0] exp_q [$];
    logic [7:0] b;
    logic [7:0] idx;
    int         n;
    int         exp_exec;
    reply_q.delete();
    exec_q.delete();
    n = 32'(rows[r].len[`DBG_LEN_W-1:0]);
    case (rows[r].op)
      OP_CHAL: begin
        send_byte(HOST_ACK, 1'b1);
        exp_q.push_back(HOST_ACK);
      end
      OP_WRITE: begin
        send_byte(HOST_WRITE, 1'b1);
        send_field(rows[r].addr);
        send_field(rows[r].len);
        // Data only after the ACK
        wait_replies(1);
        exp_q.push_back(HOST_ACK);
        for (int i = 0; i < n; i++) begin
          b   = 8'($random(seed)) ^ rows[r].pat;
          idx = 8'((rows[r].addr + 64'(i)) % 64'd256);
          send_byte(b, 1'b1);
          model_mem[idx] = b;
        end
        exp_q.push_back(HOST_EOT);
      end
      OP_READ: begin
        send_byte(HOST_READ, 1'b1);
        send_field(rows[r].addr);
        send_field(rows[r].len);
        exp_q.push_back(HOST_ACK);
        for (int i = 0; i < n; i++) begin
          idx = 8'((rows[r].addr + 64'(i)) % 64'd256);
          exp_q.push_back(model_mem[idx]);
        end
        exp_q.push_back(HOST_EOT);
      end
      OP_EXEC: begin
        send_byte(HOST_EXEC, 1'b1);
        send_field(rows[r].addr);
        exp_q.push_back(HOST_ACK);
      end
      OP_JUNK:     send_byte(rows[r].pat, 1'b1);
      OP_BADFRAME: send_byte(rows[r].pat, 1'b0);
      default: ;
    endcase
    wait_replies(exp_q.size());
    // Room for stray bytes and the exec pulse
    repeat (QUIET_FRAMES * FRAME_CYC) @(posedge clk);
    #DRV_DLY;
    if (reply_q.size() != exp_q.size()) begin
      proto_errs++;
      $display("Row %0d expected %0d reply bytes on uart_tx_o, received %0d",
               r, exp_q.size(), reply_q.size());
    end
    for (int i = 0; i < exp_q.size() && i < reply_q.size(); i++) begin
      if (reply_q[i] !== exp_q[i]) begin
        value_errs++;
        $display("** Error: uart_tx_o row %0d byte %0d expected %02h got %02h",
                 r, i, exp_q[i], reply_q[i]);
      end
    end
    exp_exec = (rows[r].op == OP_EXEC) ? 1 : 0;
    if (exec_q.size() != exp_exec) begin
      proto_errs++;
      $display("Row %0d expected %0d exec pulses, saw %0d", r, exp_exec, exec_q.size());
    end else if (exp_exec == 1 && exec_q[0] !== rows[r].entry) begin
      value_errs++;
      $display("** Error: exec_o.entry row %0d expected %016h got %016h",
               r, rows[r].entry, exec_q[0]);
    end
  endtask

  task automatic end_run();
    $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (limit_cyc != 0 && cycle_cnt > limit_cyc) begin
      proto_errs++;
      $display("Timeout, the run went past its budget of %0d cycles", limit_cyc);
      end_run();
    end
  end

  initial begin : main
    uart_rx    = 1'b1;
    seed       = 32'h2ee6;
    cycle_cnt  = 0;
    value_errs = 0;
    proto_errs = 0;
    load_table();
    limit_cyc = frame_budget();
    wait (rst == 1'b0);
    @(posedge clk);
    #DRV_DLY;
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    end_run();
  end

endmodule

/* hw/dbg_cmd_engine.sv */
/* Debug command engine
   Parses host commands and sequences ACK, data and EOT replies,
   memory accesses and the exec request */

`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module dbg_cmd_engine import uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  uart_byte_t rx_byte_i,
  output uart_byte_t tx_req_o,
  input  logic       tx_done_i,
  output mem_req_t   mem_req_o,
  input  logic [7:0] mem_rdata_i,
  output exec_req_t  exec_o
);

  localparam int unsigned LEN_BYTES = `DBG_LEN_W / 8;

  dbg_state_e              state_q;
  dbg_byte_e               cmd_q;
  logic [2:0]              cnt_q;
  logic [`DBG_ENTRY_W-1:0] addr_q;
  logic [`DBG_LEN_W-1:0]   len_q;
  logic                    tx_go_q;
  logic [7:0]              tx_byte_q;
  logic                    rd_pend_q;

  logic rx_fire;
  logic len_zero;
  logic rw_cmd;
  logic hdr_done;
  logic rd_fire;
  logic wr_fire;
  logic last_wr;
  logic ack_go;
  logic eot_go;

  ////////////////////
  // Control strobes
  ////////////////////

  assign rx_fire  = rx_byte_i.valid;
  assign len_zero = (len_q == '0);
  assign rw_cmd   = (cmd_q == CMD_READ) || (cmd_q == CMD_WRITE);

  // Eighth byte of the last header field
  assign hdr_done = rx_fire && (cnt_q == 3'd7) &&
                    ((state_q == ST_LEN) || (state_q == ST_ADDR && cmd_q == CMD_EXEC));

  // Next read byte is fetched as soon as the previous frame is done
  assign rd_fire = tx_done_i && !len_zero &&
                   ((state_q == ST_SEND_ACK && cmd_q == CMD_READ) ||
                    (state_q == ST_DATA_OUT));
  assign wr_fire = rx_fire && (state_q == ST_DATA_IN);
  assign last_wr = wr_fire && (len_q == `DBG_LEN_W'(1));

  assign ack_go = hdr_done ||
                  (state_q == ST_IDLE && rx_fire && rx_byte_i.data == BYTE_ACK);
  assign eot_go = (state_q == ST_SEND_ACK && tx_done_i && len_zero && rw_cmd) ||
                  (state_q == ST_DATA_OUT && tx_done_i && len_zero) ||
                  last_wr;

  ////////////////////
  // Outputs
  ////////////////////

  assign mem_req_o.valid = rd_fire || wr_fire;
  assign mem_req_o.we    = wr_fire;
  assign mem_req_o.addr  = addr_q[`DBG_MEM_AW-1:0];
  assign mem_req_o.wdata = rx_byte_i.data;

  // Read data goes out the cycle after its fetch
  assign tx_req_o.valid = tx_go_q || rd_pend_q;
  assign tx_req_o.data  = rd_pend_q ? mem_rdata_i : tx_byte_q;

  assign exec_o.valid = (state_q == ST_EXEC);
  assign exec_o.entry = addr_q;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      cmd_q     <= BYTE_ACK;
      cnt_q     <= '0;
      addr_q    <= '0;
      len_q     <= '0;
      tx_go_q   <= 1'b0;
      tx_byte_q <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      tx_go_q   <= ack_go || eot_go;
      rd_pend_q <= rd_fire;
      if (ack_go || eot_go) begin
        tx_byte_q <= ack_go ? BYTE_ACK : BYTE_EOT;
      end
      // Address wraps inside the memory
      if (rd_fire || wr_fire) begin
        addr_q[`DBG_MEM_AW-1:0] <= addr_q[`DBG_MEM_AW-1:0] + 1'b1;
        len_q                   <= len_q - 1'b1;
      end
      case (state_q)
        ST_IDLE: begin
          cnt_q <= '0;
          if (rx_fire) begin
            case (rx_byte_i.data)
              BYTE_ACK: begin
                cmd_q   <= BYTE_ACK;
                state_q <= ST_SEND_ACK;
              end
              CMD_READ, CMD_WRITE, CMD_EXEC: begin
                cmd_q   <= dbg_byte_e'(rx_byte_i.data);
                state_q <= ST_ADDR;
              end
              default: state_q <= ST_IDLE;
            endcase
          end
        end
        ST_ADDR: begin
          // Little endian, first byte ends up lowest
          if (rx_fire) begin
            addr_q <= {rx_byte_i.data, addr_q[`DBG_ENTRY_W-1:8]};
            cnt_q  <= cnt_q + 1'b1;
            if (cnt_q == 3'd7) begin
              state_q <= (cmd_q == CMD_EXEC) ? ST_SEND_ACK : ST_LEN;
            end
          end
        end
        ST_LEN: begin
          if (rx_fire) begin
            if (cnt_q < 3'(LEN_BYTES)) begin
              len_q[8*cnt_q +: 8] <= rx_byte_i.data;
            end
            cnt_q <= cnt_q + 1'b1;
            if (hdr_done) begin
              state_q <= ST_SEND_ACK;
            end
          end
        end
        ST_SEND_ACK: begin
          if (tx_done_i) begin
            if (cmd_q == CMD_EXEC) begin
              state_q <= ST_EXEC;
            end else if (!rw_cmd) begin
              state_q <= ST_IDLE;
            end else if (len_zero) begin
              state_q <= ST_SEND_EOT;
            end else begin
              state_q <= (cmd_q == CMD_READ) ? ST_DATA_OUT : ST_DATA_IN;
            end
          end
        end
        ST_DATA_IN: begin
          if (last_wr) begin
            state_q <= ST_SEND_EOT;
          end
        end
        ST_DATA_OUT: begin
          if (tx_done_i && len_zero) begin
            state_q <= ST_SEND_EOT;
          end
        end
        ST_SEND_EOT: begin
          if (tx_done_i) begin
            state_q <= ST_IDLE;
          end
        end
        // One-cycle exec pulse
        ST_EXEC: state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

/* hw/dbg_mem.sv */
/* Debug byte memory
   Single synchronous port with one cycle of read latency */

`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module dbg_mem import uart_dbg_pkg::*; (
  input  logic       clk,
  input  mem_req_t   req_i,
  output logic [7:0] rdata_o
);

  logic [7:0] mem_q [`DBG_MEM_DEPTH];
  logic [7:0] rdata_q;

  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        mem_q[req_i.addr] <= req_i.wdata;
      end else begin
        rdata_q <= mem_q[req_i.addr];
      end
    end
  end

  // Holds until the next read
  assign rdata_o = rdata_q;

endmodule

/* hw/uart_dbg_pkg.sv */
/* UART debug bridge types
   Protocol bytes, engine states and the structs on the internal links */

`include "uart_dbg_settings.svh"

package uart_dbg_pkg;

  // Bytes on the serial line
  typedef enum logic [7:0] {
    BYTE_EOT  = 8'h04,
    BYTE_ACK  = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13
  } dbg_byte_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_SEND_ACK,
    ST_DATA_IN,
    ST_DATA_OUT,
    ST_SEND_EOT,
    ST_EXEC
  } dbg_state_e;

  // Byte with a single-cycle strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } uart_byte_t;

  typedef struct packed {
    logic                    valid;
    logic                    we;
    logic [`DBG_MEM_AW-1:0]  addr;
    logic [7:0]              wdata;
  } mem_req_t;

  typedef struct packed {
    logic                    valid;
    logic [`DBG_ENTRY_W-1:0] entry;
  } exec_req_t;

endpackage

/* hw/uart_dbg_settings.svh */
/* UART debug bridge settings
   Bit timing, memory geometry and protocol field widths */

`ifndef UART_DBG_SETTINGS_SVH
`define UART_DBG_SETTINGS_SVH

////////////////////
// Serial line
////////////////////

// Clock cycles per serial bit
`define UART_CLKS_PER_BIT 16

////////////////////
// Memory and fields
////////////////////

`define DBG_MEM_DEPTH 256
`define DBG_MEM_AW    8
// Only the low bits of the 64-bit length field count
`define DBG_LEN_W     16
`define DBG_ENTRY_W   64

`endif

/* hw/uart_dbg_top.sv */
/* UART debug bridge top level
   Receiver, command engine, byte memory and transmitter */

`timescale 1ns/1ps

module uart_dbg_top import uart_dbg_pkg::*; (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      uart_rx_i,
  output logic      uart_tx_o,
  output exec_req_t exec_o
);

  uart_byte_t rx_byte;
  uart_byte_t tx_req;
  logic       tx_done;
  mem_req_t   mem_req;
  logic [7:0] mem_rdata;

  uart_rx u_uart_rx (
    .clk    ( clk       ),
    .rst_i  ( rst_i     ),
    .rx_i   ( uart_rx_i ),
    .byte_o ( rx_byte   )
  );

  dbg_cmd_engine u_dbg_cmd_engine (
    .clk         ( clk       ),
    .rst_i       ( rst_i     ),
    .rx_byte_i   ( rx_byte   ),
    .tx_req_o    ( tx_req    ),
    .tx_done_i   ( tx_done   ),
    .mem_req_o   ( mem_req   ),
    .mem_rdata_i ( mem_rdata ),
    .exec_o      ( exec_o    )
  );

  dbg_mem u_dbg_mem (
    .clk     ( clk       ),
    .req_i   ( mem_req   ),
    .rdata_o ( mem_rdata )
  );

  uart_tx u_uart_tx (
    .clk    ( clk       ),
    .rst_i  ( rst_i     ),
    .req_i  ( tx_req    ),
    .tx_o   ( uart_tx_o ),
    .done_o ( tx_done   )
  );

endmodule

/* hw/uart_rx.sv */
/* UART receiver, 8N1
   Oversamples the line and strobes every byte whose stop bit is high */

`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_rx import uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       rx_i,
  output uart_byte_t byte_o
);

  localparam int unsigned   CW        = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [CW-1:0] HALF_LAST = CW'(`UART_CLKS_PER_BIT / 2 - 1);
  localparam logic [CW-1:0] BIT_LAST  = CW'(`UART_CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e     state_q;
  logic [2:0]    sync_q;
  logic [CW-1:0] clk_cnt_q;
  logic [2:0]    bit_cnt_q;
  logic [7:0]    data_q;
  logic          valid_q;
  logic          rx_s;
  logic          fall;
  logic          bit_end;

  // Two sync flops, the third one finds the falling edge
  always_ff @(posedge clk) begin
    if (rst_i) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[1:0], rx_i};
    end
  end

  assign rx_s    = sync_q[1];
  assign fall    = sync_q[2] & ~sync_q[1];
  assign bit_end = (clk_cnt_q == BIT_LAST);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q   <= 1'b0;
      clk_cnt_q <= clk_cnt_q + 1'b1;
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (fall) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Glitch if the line is back high mid start bit
          if (clk_cnt_q == HALF_LAST) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          // Framing error drops the byte
          if (bit_end) begin
            valid_q <= rx_s;
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && bit_end) begin
      data_q <= {rx_s, data_q[7:1]};
    end
  end

  assign byte_o.valid = valid_q;
  assign byte_o.data  = data_q;

endmodule

/* hw/uart_tx.sv */
/* UART transmitter, 8N1
   Sends one frame per request and pulses done after the stop bit */

`timescale 1ns/1ps
`include "uart_dbg_settings.svh"

module uart_tx import uart_dbg_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  uart_byte_t req_i,
  output logic       tx_o,
  output logic       done_o
);

  localparam int unsigned   CW       = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [CW-1:0] BIT_LAST = CW'(`UART_CLKS_PER_BIT - 1);

  logic          busy_q;
  logic [9:0]    frame_q;
  logic [3:0]    bit_cnt_q;
  logic [CW-1:0] clk_cnt_q;
  logic          done_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      frame_q   <= '1;
      bit_cnt_q <= '0;
      clk_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        // Stop, data and start bit, shifted out from bit 0
        if (req_i.valid) begin
          busy_q    <= 1'b1;
          frame_q   <= {1'b1, req_i.data, 1'b0};
          bit_cnt_q <= '0;
          clk_cnt_q <= '0;
        end
      end else if (clk_cnt_q == BIT_LAST) begin
        clk_cnt_q <= '0;
        frame_q   <= {1'b1, frame_q[9:1]};
        if (bit_cnt_q == 4'd9) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

  // Line idles high once the frame has shifted out
  assign tx_o   = frame_q[0];
  assign done_o = done_q;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the UART debug bridge testbench with Verilator

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module uart_dbg_tb \
  -f all.f -o uart_dbg_sim &&
  ./obj_dir/uart_dbg_sim | tee sim.log &&
  grep -q "TEST RESULT: PASS" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
